/* tb.f */
rtl/boot_pkg.sv
rtl/boot_ram.sv
rtl/block_copy.sv
rtl/loader_regs.sv
rtl/boot_sequencer.sv
rtl/boot_top.sv
tests/tb_boot_top.sv

/* Makefile */
# Verilator build and run of the boot loader testbench.

VERILATOR ?= verilator
TOP       ?= tb_boot_top
FLAGS     ?= --binary --timing --assert -Wno-fatal
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

# build, run, and pass only when the pass line is printed.
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f tb.f
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "=== PASS ==="

clean:
	rm -rf $(OBJ_DIR)

/* tests/tb_boot_top.sv */
`timescale 1ns/1ps
// testbench for the boot loader top level.
// clock, reset, credit-driven storage source model, directed tests.
// watchdog and closing summary.
module tb_boot_top
	import boot_pkg::*;
();

	// per-boot slack for polls, register accesses and readback setup.
	localparam int BOOT_SLACK  = 6 * (POLL_WAIT + 4) + 100;
	localparam int MEDIA_DELAY = 20;
	localparam int WINDOW      = 200;
	// budget for loads of 32, BOOT_WORDS and 10 words.
	localparam int TIMEOUT_CYC = (32 * 8 + BOOT_SLACK) + (BOOT_WORDS * 8 + BOOT_SLACK)
		+ (10 * 8 + BOOT_SLACK) + WINDOW + 2 * MEDIA_DELAY;

	logic              CLK_I;
	logic              RST_I;
	logic [SIZE_W-1:0] boot_words;
	logic              media_ready;
	logic              st_credit;
	logic              st_valid = 1'b0;
	logic [31:0]       st_data = '0;
	logic [RAM_AW-1:0] rd_addr;
	logic [31:0]       rd_data;
	logic              boot_done;

	// source model state.
	// expected ram image that survives reset like the ram.
	logic [31:0] exp_words [BOOT_WORDS];
	logic [31:0] word;
	int          credit_cnt;
	int          sent_cnt;
	int          gap;
	int          max_gap;
	int          peak_out;
	int          src_err_cnt;
	int          err_cnt;

	boot_top u_dut (
		.CLK_I       (CLK_I),
		.RST_I       (RST_I),
		.boot_words  (boot_words),
		.media_ready (media_ready),
		.st_credit   (st_credit),
		.st_valid    (st_valid),
		.st_data     (st_data),
		.rd_addr     (rd_addr),
		.rd_data     (rd_data),
		.boot_done   (boot_done)
	);

	// 40 ns clock.
	initial begin
		CLK_I = 1'b0;
		forever #20 CLK_I = ~CLK_I;
	end

	// storage source.
	// one word per held credit with a random gap between words.
	always @(posedge CLK_I) begin
		if (RST_I) begin
			credit_cnt = 0;
			sent_cnt   = 0;
			gap        = 0;
			st_valid  <= 1'b0;
			st_data   <= '0;
		end else begin
			if (st_credit)
				credit_cnt = credit_cnt + 1;
			if (credit_cnt - sent_cnt > peak_out)
				peak_out = credit_cnt - sent_cnt;
			// outstanding credits bounded by fifo depth.
			assert (credit_cnt - sent_cnt <= CREDIT_MAX) else begin
				src_err_cnt++;
				$display("error: credit_bound: expected at most %0d, actual %0d",
					CREDIT_MAX, credit_cnt - sent_cnt);
			end
			st_valid <= 1'b0;
			if (credit_cnt > sent_cnt) begin
				if (gap == 0) begin
					word = $urandom;
					st_valid <= 1'b1;
					st_data  <= word;
					exp_words[sent_cnt] = word;
					sent_cnt = sent_cnt + 1;
					gap = int'($urandom % (max_gap + 1));
				end else begin
					gap = gap - 1;
				end
			end
		end
	end

	// compare and count.
	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		assert (act == exp) else begin
			err_cnt++;
			$display("error: %s: expected %0h, actual %0h", name, exp, act);
		end
	endtask

	// four reset cycles with the strap and media level applied.
	task automatic apply_reset(input int words, input logic ready);
		@(posedge CLK_I);
		RST_I       <= 1'b1;
		boot_words  <= SIZE_W'(words);
		media_ready <= ready;
		repeat (4) @(posedge CLK_I);
		RST_I <= 1'b0;
	endtask

	task automatic raise_media(input int delay);
		repeat (delay) @(posedge CLK_I);
		media_ready <= 1'b1;
	endtask

	// spin until the sequencer flags completion.
	task automatic wait_boot_done();
		while (!boot_done)
			@(posedge CLK_I);
	endtask

	// pipelined readback with data checked two edges after the address.
	task automatic check_ram(input string name, input int count);
		for (int i = 0; i < count + 2; i++) begin
			@(posedge CLK_I);
			if (i >= 2)
				check_value($sformatf("%s[%0d]", name, i - 2), exp_words[i - 2], rd_data);
			if (i < count)
				rd_addr <= RAM_AW'(i);
		end
	endtask

	// no media means no credits and no boot.
	task automatic test_not_ready_hold();
		max_gap = 3;
		apply_reset(32, 1'b0);
		repeat (WINDOW) begin
			@(posedge CLK_I);
			check_value("not_ready_hold boot_done", 32'd0, 32'(boot_done));
			check_value("not_ready_hold st_credit", 32'd0, 32'(st_credit));
		end
	endtask

	// continues from the not-ready boot.
	task automatic test_full_load();
		max_gap     = 0;
		boot_words  <= SIZE_W'(32);
		media_ready <= 1'b1;
		wait_boot_done();
		check_value("full_load credits", 32'd32, 32'(credit_cnt));
		check_value("full_load words", 32'd32, 32'(sent_cnt));
		check_ram("full_load", 32);
	endtask

	// slow source over a full-size image.
	task automatic test_back_pressure();
		max_gap = 3;
		apply_reset(BOOT_WORDS, 1'b0);
		raise_media(MEDIA_DELAY);
		wait_boot_done();
		check_value("back_pressure credits", 32'(BOOT_WORDS), 32'(credit_cnt));
		check_ram("back_pressure", BOOT_WORDS);
	endtask

	// peak over all loads and no credits after the last one.
	task automatic test_credit_bound();
		assert (peak_out <= CREDIT_MAX) else begin
			err_cnt++;
			$display("error: credit_bound peak: expected at most %0d, actual %0d",
				CREDIT_MAX, peak_out);
		end
		check_value("credit_bound late credits", 32'(BOOT_WORDS), 32'(credit_cnt));
	endtask

	// upper words keep the previous image.
	task automatic test_reboot_smaller();
		max_gap = 1;
		apply_reset(10, 1'b0);
		raise_media(MEDIA_DELAY);
		wait_boot_done();
		check_value("reboot_smaller credits", 32'd10, 32'(credit_cnt));
		check_ram("reboot_smaller", BOOT_WORDS);
	endtask

	initial begin
		void'($urandom(83304));
		RST_I       = 1'b1;
		boot_words  = '0;
		media_ready = 1'b0;
		rd_addr     = '0;
		max_gap     = 0;
		peak_out    = 0;
		err_cnt     = 0;
		src_err_cnt = 0;
		test_not_ready_hold();
		test_full_load();
		test_back_pressure();
		test_credit_bound();
		test_reboot_smaller();
		$display("errors: checks %0d, stream %0d, total %0d",
			err_cnt, src_err_cnt, err_cnt + src_err_cnt);
		if (err_cnt + src_err_cnt == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	// watchdog.
	initial begin
		repeat (TIMEOUT_CYC) @(posedge CLK_I);
		$display("timeout: run not finished after %0d cycles, errors so far %0d",
			TIMEOUT_CYC, err_cnt + src_err_cnt);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

/* rtl/boot_top.sv */
`timescale 1ns/1ps
// boot loader top level.
// sequencer, loader registers, copy engine and boot ram.
module boot_top
	import boot_pkg::*;
(
	input  logic              CLK_I,
	input  logic              RST_I,
	input  logic [SIZE_W-1:0] boot_words,
	input  logic              media_ready,
	output logic              st_credit,
	input  logic              st_valid,
	input  logic [31:0]       st_data,
	input  logic [RAM_AW-1:0] rd_addr,
	output logic [31:0]       rd_data,
	output logic              boot_done
);

	// wishbone between sequencer and registers.
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [29:0] wb_adr;
	logic [31:0] wb_dat_w;
	logic [31:0] wb_dat_r;
	logic        wb_ack;

	// register block to copy engine.
	logic              load_start;
	logic [SIZE_W-1:0] load_size;
	logic              load_busy;

	// copy engine to ram.
	logic              wr_en;
	logic [RAM_AW-1:0] wr_addr;
	logic [31:0]       wr_data;

	boot_sequencer u_seq (
		.CLK_I      (CLK_I),
		.RST_I      (RST_I),
		.boot_words (boot_words),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_we      (wb_we),
		.wb_adr     (wb_adr),
		.wb_dat_w   (wb_dat_w),
		.wb_dat_r   (wb_dat_r),
		.wb_ack     (wb_ack),
		.boot_done  (boot_done)
	);

	loader_regs u_regs (
		.CLK_I       (CLK_I),
		.RST_I       (RST_I),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_adr      (wb_adr),
		.wb_dat_w    (wb_dat_w),
		.wb_dat_r    (wb_dat_r),
		.wb_ack      (wb_ack),
		.media_ready (media_ready),
		.load_start  (load_start),
		.load_size   (load_size),
		.load_busy   (load_busy)
	);

	block_copy u_copy (
		.CLK_I      (CLK_I),
		.RST_I      (RST_I),
		.load_start (load_start),
		.load_size  (load_size),
		.load_busy  (load_busy),
		.st_credit  (st_credit),
		.st_valid   (st_valid),
		.st_data    (st_data),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data)
	);

	boot_ram u_ram (
		.CLK_I   (CLK_I),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

endmodule

/* rtl/boot_sequencer.sv */
`timescale 1ns/1ps
// boot sequencer, the Wishbone master of the loader.
// polls status, programs size and command, then flags boot completion.
module boot_sequencer
	import boot_pkg::*;
(
	input  logic              CLK_I,
	input  logic              RST_I,
	input  logic [SIZE_W-1:0] boot_words,
	output logic              wb_cyc,
	output logic              wb_stb,
	output logic              wb_we,
	output logic [29:0]       wb_adr,
	output logic [31:0]       wb_dat_w,
	input  logic [31:0]       wb_dat_r,
	input  logic              wb_ack,
	output logic              boot_done
);

	seq_state_e state;
	// counts the idle gap between polls.
	logic [$clog2(POLL_WAIT)-1:0] wait_cnt;

	always_ff @(posedge CLK_I) begin
		if (RST_I) begin
			state     <= S_CHECK_STATUS;
			wb_cyc    <= 1'b0;
			wb_stb    <= 1'b0;
			wb_we     <= 1'b0;
			wait_cnt  <= '0;
			boot_done <= 1'b0;
		end else begin
			case (state)
				// wait for the loader to report idle.
				S_CHECK_STATUS: begin
					wb_cyc <= 1'b1;
					wb_stb <= 1'b1;
					wb_we  <= 1'b0;
					wb_adr <= {REG_BASE[29:2], REG_STATUS};
					state  <= S_CHECK_STATUS_WAIT;
				end
				S_CHECK_STATUS_WAIT: begin
					if (wb_ack) begin
						wb_cyc <= 1'b0;
						wb_stb <= 1'b0;
						if (wb_dat_r == ST_IDLE)
							state <= S_SET_SIZE;
						else
							state <= S_CHECK_STATUS_GAP;
					end
				end
				S_CHECK_STATUS_GAP: begin
					if (int'(wait_cnt) == POLL_WAIT - 1) begin
						wait_cnt <= '0;
						state    <= S_CHECK_STATUS;
					end else begin
						wait_cnt <= wait_cnt + 1'b1;
					end
				end
				// size comes straight from the strap.
				S_SET_SIZE: begin
					wb_cyc   <= 1'b1;
					wb_stb   <= 1'b1;
					wb_we    <= 1'b1;
					wb_adr   <= {REG_BASE[29:2], REG_SIZE};
					wb_dat_w <= 32'(boot_words);
					state    <= S_SET_SIZE_WAIT;
				end
				S_SET_SIZE_WAIT: begin
					if (wb_ack) begin
						wb_cyc <= 1'b0;
						wb_stb <= 1'b0;
						wb_we  <= 1'b0;
						state  <= S_SET_CONTROL;
					end
				end
				// kick off the load.
				S_SET_CONTROL: begin
					wb_cyc   <= 1'b1;
					wb_stb   <= 1'b1;
					wb_we    <= 1'b1;
					wb_adr   <= {REG_BASE[29:2], REG_CONTROL};
					wb_dat_w <= CMD_LOAD;
					state    <= S_SET_CONTROL_WAIT;
				end
				S_SET_CONTROL_WAIT: begin
					if (wb_ack) begin
						wb_cyc <= 1'b0;
						wb_stb <= 1'b0;
						wb_we  <= 1'b0;
						state  <= S_CHECK_DONE;
					end
				end
				// poll again until the load is over.
				S_CHECK_DONE: begin
					wb_cyc <= 1'b1;
					wb_stb <= 1'b1;
					wb_we  <= 1'b0;
					wb_adr <= {REG_BASE[29:2], REG_STATUS};
					state  <= S_CHECK_DONE_WAIT;
				end
				S_CHECK_DONE_WAIT: begin
					if (wb_ack) begin
						wb_cyc <= 1'b0;
						wb_stb <= 1'b0;
						if (wb_dat_r == ST_IDLE) begin
							boot_done <= 1'b1;
							state     <= S_FINISHED;
						end else begin
							state <= S_CHECK_DONE_GAP;
						end
					end
				end
				S_CHECK_DONE_GAP: begin
					if (int'(wait_cnt) == POLL_WAIT - 1) begin
						wait_cnt <= '0;
						state    <= S_CHECK_DONE;
					end else begin
						wait_cnt <= wait_cnt + 1'b1;
					end
				end
				// parked until reset.
				S_FINISHED: state <= S_FINISHED;
				default: state <= S_CHECK_STATUS;
			endcase
		end
	end

	// done is sticky until reset.
	assert property (@(posedge CLK_I) disable iff (RST_I) boot_done |=> boot_done)
		else $error("boot_done dropped without reset");
	// no strobe outside a cycle.
	assert property (@(posedge CLK_I) disable iff (RST_I) wb_stb |-> wb_cyc)
		else $error("wb_stb high without wb_cyc");

endmodule

/* rtl/loader_regs.sv */
`timescale 1ns/1ps
// loader register block, a Wishbone slave.
// status, size and control registers with a one-cycle acknowledge.
module loader_regs
	import boot_pkg::*;
(
	input  logic              CLK_I,
	input  logic              RST_I,
	input  logic              wb_cyc,
	input  logic              wb_stb,
	input  logic              wb_we,
	input  logic [29:0]       wb_adr,
	input  logic [31:0]       wb_dat_w,
	output logic [31:0]       wb_dat_r,
	output logic              wb_ack,
	input  logic              media_ready,
	output logic              load_start,
	output logic [SIZE_W-1:0] load_size,
	input  logic              load_busy
);

	logic        reg_hit;
	logic [1:0]  reg_off;
	logic        wr_fire;
	status_e     status;
	cmd_e        ctrl_q;
	logic [31:0] rd_val;

	// block decode on the upper word address bits.
	assign reg_hit = wb_adr[29:2] == REG_BASE[29:2];
	assign reg_off = wb_adr[1:0];
	// writes land on the ack cycle.
	assign wr_fire = wb_cyc && wb_stb && wb_we && wb_ack && reg_hit;

	// a running load wins over media state.
	always_comb begin
		if (load_busy)
			status = ST_BUSY;
		else if (!media_ready)
			status = ST_NOT_READY;
		else
			status = ST_IDLE;
	end

	// unknown offsets read as zero.
	always_comb begin
		rd_val = '0;
		if (reg_hit) begin
			case (reg_off)
				REG_STATUS:  rd_val = status;
				REG_SIZE:    rd_val = 32'(load_size);
				REG_CONTROL: rd_val = ctrl_q;
				default:     rd_val = '0;
			endcase
		end
	end

	always_ff @(posedge CLK_I) begin
		if (RST_I) begin
			wb_ack     <= 1'b0;
			load_start <= 1'b0;
			load_size  <= '0;
			ctrl_q     <= CMD_NOP;
		end else begin
			// ack one cycle after strobe, never back to back.
			wb_ack     <= wb_cyc && wb_stb && !wb_ack;
			load_start <= 1'b0;
			if (wr_fire && reg_off == REG_SIZE)
				load_size <= wb_dat_w[SIZE_W-1:0];
			if (wr_fire && reg_off == REG_CONTROL) begin
				ctrl_q <= cmd_e'(wb_dat_w);
				// load command dropped while busy.
				load_start <= (wb_dat_w == CMD_LOAD) && !load_busy;
			end
		end
	end

	// read data sampled with the access.
	always_ff @(posedge CLK_I) begin
		if (wb_cyc && wb_stb && !wb_ack)
			wb_dat_r <= rd_val;
	end

	assert property (@(posedge CLK_I) disable iff (RST_I) wb_ack |=> !wb_ack)
		else $error("wb_ack held for two cycles");

endmodule

/* rtl/block_copy.sv */
`timescale 1ns/1ps
// storage stream receiver with credit flow control.
// buffers words in a small fifo and writes them to boot ram from address 0.
module block_copy
	import boot_pkg::*;
(
	input  logic              CLK_I,
	input  logic              RST_I,
	input  logic              load_start,
	input  logic [SIZE_W-1:0] load_size,
	output logic              load_busy,
	output logic              st_credit,
	input  logic              st_valid,
	input  logic [31:0]       st_data,
	output logic              wr_en,
	output logic [RAM_AW-1:0] wr_addr,
	output logic [31:0]       wr_data
);

	// credits still to be granted in this load.
	logic [SIZE_W-1:0] credit_left;
	// granted credits with no word back yet.
	logic [$clog2(CREDIT_MAX+1)-1:0] out_cnt;
	// words written so far and the ram address.
	logic [SIZE_W-1:0] wr_cnt;
	logic [31:0] fifo_mem [CREDIT_MAX];
	logic [$clog2(CREDIT_MAX)-1:0] wp;
	logic [$clog2(CREDIT_MAX)-1:0] rp;
	logic [$clog2(CREDIT_MAX+1)-1:0] fifo_cnt;

	// fifo head goes to ram whenever present.
	assign wr_en   = fifo_cnt != '0;
	assign wr_addr = wr_cnt[RAM_AW-1:0];
	assign wr_data = fifo_mem[rp];

	// grant only into slots not already promised.
	// the slot freed by this cycle's write counts.
	assign st_credit = load_busy && (credit_left != '0)
		&& (CREDIT_MAX - int'(fifo_cnt) + int'(wr_en) > int'(out_cnt));

	// fifo storage.
	always_ff @(posedge CLK_I) begin
		if (st_valid)
			fifo_mem[wp] <= st_data;
	end

	always_ff @(posedge CLK_I) begin
		if (RST_I) begin
			load_busy   <= 1'b0;
			credit_left <= '0;
			out_cnt     <= '0;
			wr_cnt      <= '0;
			wp          <= '0;
			rp          <= '0;
			fifo_cnt    <= '0;
		end else begin
			// armed on start and cleared after the last write.
			if (load_start && !load_busy) begin
				load_busy   <= 1'b1;
				credit_left <= load_size;
				wr_cnt      <= '0;
			end else if (wr_en && (wr_cnt + 1'b1 == load_size)) begin
				load_busy <= 1'b0;
			end
			if (st_credit)
				credit_left <= credit_left - 1'b1;
			if (wr_en)
				wr_cnt <= wr_cnt + 1'b1;
			// up on a credit and down on a word.
			if (st_credit && !st_valid)
				out_cnt <= out_cnt + 1'b1;
			else if (!st_credit && st_valid)
				out_cnt <= out_cnt - 1'b1;
			// fifo pointers.
			if (st_valid)
				wp <= wp + 1'b1;
			if (wr_en)
				rp <= rp + 1'b1;
			if (st_valid && !wr_en)
				fifo_cnt <= fifo_cnt + 1'b1;
			else if (!st_valid && wr_en)
				fifo_cnt <= fifo_cnt - 1'b1;
		end
	end

	// source must hold a credit to send.
	assert property (@(posedge CLK_I) disable iff (RST_I) st_valid |-> out_cnt != '0)
		else $error("st_valid without an outstanding credit");
	// words held plus words promised fit the fifo.
	assert property (@(posedge CLK_I) disable iff (RST_I)
		int'(fifo_cnt) + int'(out_cnt) <= CREDIT_MAX)
		else $error("fifo overflow");

endmodule

/* rtl/boot_ram.sv */
`timescale 1ns/1ps
// boot memory, one write port and one registered read port.
module boot_ram
	import boot_pkg::*;
(
	input  logic              CLK_I,
	input  logic              wr_en,
	input  logic [RAM_AW-1:0] wr_addr,
	input  logic [31:0]       wr_data,
	input  logic [RAM_AW-1:0] rd_addr,
	output logic [31:0]       rd_data
);

	// contents survive reset.
	logic [31:0] mem [BOOT_WORDS];

	// write side, fed by the copy engine.
	always_ff @(posedge CLK_I) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// cpu side, one cycle read latency.
	// old data on a same-address collision.
	always_ff @(posedge CLK_I) begin
		rd_data <= mem[rd_addr];
	end

endmodule

/* rtl/boot_pkg.sv */
// shared definitions for the boot loader subsystem.
// register map, status and command codes, sequencer states, sizing.
package boot_pkg;

	// word address of the loader register block.
	localparam logic [29:0] REG_BASE = 30'h30000000;

	// word offsets within the block.
	localparam logic [1:0] REG_STATUS  = 2'd0;
	localparam logic [1:0] REG_SIZE    = 2'd2;
	localparam logic [1:0] REG_CONTROL = 2'd3;

	// status register values.
	typedef enum logic [31:0] {
		ST_NOT_READY = 32'd0,
		ST_BUSY      = 32'd1,
		ST_IDLE      = 32'd2
	} status_e;

	// control register opcodes.
	typedef enum logic [31:0] {
		CMD_NOP  = 32'd0,
		CMD_LOAD = 32'd2
	} cmd_e;

	// boot sequencer states, one issue/wait pair per register access.
	typedef enum logic [3:0] {
		S_CHECK_STATUS,
		S_CHECK_STATUS_WAIT,
		S_CHECK_STATUS_GAP,
		S_SET_SIZE,
		S_SET_SIZE_WAIT,
		S_SET_CONTROL,
		S_SET_CONTROL_WAIT,
		S_CHECK_DONE,
		S_CHECK_DONE_WAIT,
		S_CHECK_DONE_GAP,
		S_FINISHED
	} seq_state_e;

	// ram depth and largest boot image in words.
	localparam int BOOT_WORDS = 512;
	localparam int RAM_AW     = 9;
	// size strap and SIZE register width, holds up to 512.
	localparam int SIZE_W     = 10;
	// fifo depth, also the credit limit.
	localparam int CREDIT_MAX = 4;
	// idle cycles between status polls.
	localparam int POLL_WAIT  = 64;

endpackage
